//--- psum_pkg.sv
package psum_pkg;

  // --------------------------------------------------
  // data widths
  // --------------------------------------------------
  localparam int psum_w = 16;          // one partial sum
  localparam int word_w = 32;          // one glb word, carries two psums

  // --------------------------------------------------
  // buffer geometry
  // --------------------------------------------------
  localparam int fifo_depth = 4;       // psums held per row
  localparam int words_per_row = 2;    // glb words needed to fill a row
  localparam int row_num_default = 32; // pe rows, top level default

  // glb word as seen on the load channel
  // hi is the first psum of the pair, lo the second
  typedef struct packed {
    logic [psum_w-1:0] hi;
    logic [psum_w-1:0] lo;
  } load_word_t;

  // controller states
  typedef enum logic [1:0] {
    st_idle      = 2'd0, // waiting for first word of a pass
    st_load      = 2'd1, // counting words into the row fifos
    st_drain_req = 2'd2, // step issued, opsum_req up until ack
    st_drain_rel = 2'd3  // waiting for sink to drop ack
  } ctrl_state_t;

endpackage

//--- ipsum_loader.sv
`timescale 1ns/1ps

module ipsum_loader (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 load_req,
  input  logic                 load_hold,   // controller busy draining
  input  psum_pkg::load_word_t load_word,
  output logic                 load_ack,
  output logic                 store,       // one cycle per accepted word
  output psum_pkg::load_word_t store_word
);

  // --------------------------------------------------
  // four-phase receiver
  // --------------------------------------------------
  // req up + ack low  -> take word, raise ack
  // req low + ack up  -> drop ack, channel idle again

  logic accept;   // phase 1 seen and allowed
  logic req_drop; // phase 3 seen

  // new word only when the previous handshake fully closed
  assign accept   = load_req && !load_ack && !load_hold;
  assign req_drop = !load_req && load_ack;

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      load_ack <= 1'b0;
      store    <= 1'b0;
    end else begin
      store <= accept; // ack is high next cycle, so this stays one cycle wide
      if (accept) begin
        load_ack <= 1'b1;
      end else if (req_drop) begin
        load_ack <= 1'b0; // phase 4
      end
    end
  end

  // word captured with the strobe
  // buffer sees data and store in the same cycle
  always_ff @(posedge clk) begin
    if (accept) begin
      store_word <= load_word;
    end
  end

endmodule

//--- ipsum_buffer.sv
`timescale 1ns/1ps

module ipsum_buffer #(
  parameter int row_num = 32
) (
  input  logic                                      clk,
  input  logic                                      reset,
  input  logic                                      store,
  input  logic                                      step,
  input  psum_pkg::load_word_t                      store_word,
  output logic [row_num-1:0][psum_pkg::psum_w-1:0] ipsum_vec
);

  import psum_pkg::*;

  localparam int per_word = word_w / psum_w;   // psums per glb word
  localparam int ptr_w    = (row_num > 1) ? $clog2(row_num) : 1;
  localparam int half_w   = (words_per_row > 1) ? $clog2(words_per_row) : 1;

  // --------------------------------------------------
  // write steering
  // --------------------------------------------------
  logic [half_w-1:0] half_q;  // word index within the current row
  logic [ptr_w-1:0]  row_ptr; // row taking the next word
  logic              half_last;
  logic              row_last;

  assign half_last = (half_q == half_w'(words_per_row - 1));
  assign row_last  = (row_ptr == ptr_w'(row_num - 1));

  // advance per stored word only, a paused source keeps its place
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      half_q  <= '0;
      row_ptr <= '0;
    end else if (store) begin
      if (half_last) begin
        half_q <= '0;
        if (row_last) begin
          row_ptr <= '0; // wrap for next pass
        end else begin
          row_ptr <= row_ptr + 1'b1;
        end
      end else begin
        half_q <= half_q + 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // row fifos
  // --------------------------------------------------
  // entry 0 is newest, entry fifo_depth-1 feeds the reducer
  for (genvar r = 0; r < row_num; r++) begin : g_row
    logic [fifo_depth-1:0][psum_w-1:0] fifo_q;
    logic                              hit;

    assign hit = store && (row_ptr == ptr_w'(r));

    always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
        fifo_q <= '0;
      end else if (hit) begin
        fifo_q[0] <= store_word.hi;
        fifo_q[1] <= store_word.lo;
        // earlier word moves one word deeper
        for (int i = per_word; i < fifo_depth; i++) begin
          fifo_q[i] <= fifo_q[i-per_word];
        end
      end else if (step) begin
        fifo_q[0] <= '0; // drained slots come back empty
        for (int i = 1; i < fifo_depth; i++) begin
          fifo_q[i] <= fifo_q[i-1];
        end
      end
    end

    assign ipsum_vec[r] = fifo_q[fifo_depth-1]; // oldest psum out
  end

endmodule

//--- psum_reducer.sv
`timescale 1ns/1ps

module psum_reducer #(
  parameter int row_num = 32
) (
  input  logic                                      clk,
  input  logic                                      reset,
  input  logic                                      step,
  input  logic [row_num-1:0][psum_pkg::psum_w-1:0] ipsum_vec,
  input  logic [row_num-1:0][psum_pkg::psum_w-1:0] pe_psum,
  output logic [row_num-1:0][psum_pkg::psum_w-1:0] opsum
);

  import psum_pkg::*;

  // --------------------------------------------------
  // row adders
  // --------------------------------------------------
  // plain psum_w bit add, overflow wraps mod 2^16
  logic [row_num-1:0][psum_w-1:0] sum;

  for (genvar r = 0; r < row_num; r++) begin : g_add
    assign sum[r] = ipsum_vec[r] + pe_psum[r]; // carry out dropped
  end

  // --------------------------------------------------
  // result register
  // --------------------------------------------------
  // ipsum_vec still shows the pre-shift entry on the step cycle,
  // so the buffer shift and this load land on the same edge
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      opsum <= '0;
    end else if (step) begin
      opsum <= sum; // held for the whole output handshake
    end
  end

endmodule

//--- psum_ctrl.sv
`timescale 1ns/1ps

module psum_ctrl #(
  parameter int row_num = 32
) (
  input  logic clk,
  input  logic reset,
  input  logic store,
  input  logic opsum_ack,
  output logic step,      // one drain beat
  output logic opsum_req,
  output logic load_hold, // blocks load acks while draining
  output logic pass_done
);

  import psum_pkg::*;

  localparam int words_total = words_per_row * row_num; // always >= 2
  localparam int wcnt_w      = $clog2(words_total);
  localparam int beat_w      = $clog2(fifo_depth);

  ctrl_state_t       state;
  logic [wcnt_w-1:0] word_cnt;
  logic [beat_w-1:0] beat_cnt;
  logic              last_word;
  logic              last_beat;

  assign last_word = (word_cnt == wcnt_w'(words_total - 1));
  assign last_beat = (beat_cnt == beat_w'(fifo_depth - 1));

  // from state directly, no loader ack once a drain starts
  assign load_hold = (state == st_drain_req) || (state == st_drain_rel);

  // --------------------------------------------------
  // word counter
  // --------------------------------------------------
  // counts every stored word, wraps at a full buffer
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      word_cnt <= '0;
    end else if (store) begin
      if (last_word) begin
        word_cnt <= '0;
      end else begin
        word_cnt <= word_cnt + 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // pass fsm
  // --------------------------------------------------
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      state     <= st_idle;
      beat_cnt  <= '0;
      step      <= 1'b0;
      opsum_req <= 1'b0;
      pass_done <= 1'b0;
    end else begin
      step      <= 1'b0; // strobes
      pass_done <= 1'b0;
      unique case (state)
        st_idle: begin
          if (store) state <= st_load; // first word of the pass
        end
        st_load: begin
          if (store && last_word) begin
            step     <= 1'b1; // first beat right after the last word
            beat_cnt <= '0;
            state    <= st_drain_req;
          end
        end
        st_drain_req: begin
          if (step) begin
            opsum_req <= 1'b1; // opsum registered on the step edge
          end else if (opsum_req && opsum_ack) begin
            opsum_req <= 1'b0; // phase 3
            state     <= st_drain_rel;
          end
        end
        st_drain_rel: begin
          if (!opsum_ack) begin // handshake closed
            if (last_beat) begin
              pass_done <= 1'b1;
              state     <= st_idle;
            end else begin
              beat_cnt <= beat_cnt + 1'b1;
              step     <= 1'b1;
              state    <= st_drain_req;
            end
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

//--- psum_top.sv
`timescale 1ns/1ps

module psum_top #(
  parameter int row_num = psum_pkg::row_num_default
) (
  input  logic                                      clk,
  input  logic                                      reset,
  input  logic                                      load_req,
  input  psum_pkg::load_word_t                      load_word,
  output logic                                      load_ack,
  input  logic [row_num-1:0][psum_pkg::psum_w-1:0] pe_psum,
  output logic [row_num-1:0][psum_pkg::psum_w-1:0] opsum,
  output logic                                      opsum_req,
  input  logic                                      opsum_ack,
  output logic                                      pass_done
);

  import psum_pkg::*;

  logic                           store;      // loader strobe
  load_word_t                     store_word;
  logic                           step;       // drain beat
  logic                           load_hold;
  logic [row_num-1:0][psum_w-1:0] ipsum_vec;  // buffer heads

  // --------------------------------------------------
  // load side
  // --------------------------------------------------
  ipsum_loader u_loader (
    .clk        (clk),
    .reset      (reset),
    .load_req   (load_req),
    .load_hold  (load_hold),
    .load_word  (load_word),
    .load_ack   (load_ack),
    .store      (store),
    .store_word (store_word)
  );

  psum_ctrl #(.row_num(row_num)) u_ctrl (
    .clk       (clk),
    .reset     (reset),
    .store     (store),
    .opsum_ack (opsum_ack),
    .step      (step),
    .opsum_req (opsum_req),
    .load_hold (load_hold),
    .pass_done (pass_done)
  );

  // --------------------------------------------------
  // datapath
  // --------------------------------------------------
  ipsum_buffer #(.row_num(row_num)) u_buffer (
    .clk        (clk),
    .reset      (reset),
    .store      (store),
    .step       (step),
    .store_word (store_word),
    .ipsum_vec  (ipsum_vec)
  );

  psum_reducer #(.row_num(row_num)) u_reducer (
    .clk       (clk),
    .reset     (reset),
    .step      (step),
    .ipsum_vec (ipsum_vec),
    .pe_psum   (pe_psum),
    .opsum     (opsum)
  );

endmodule

//--- tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
  parameter real half_period = 4.0 // 8 ns period
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always #(half_period) clk = ~clk;

endmodule

//--- psum_asserts.sv
`timescale 1ns/1ps

module psum_asserts (
  input logic clk,
  input logic reset,
  input logic load_req,
  input logic load_ack,
  input logic store,
  input logic step,
  input logic opsum_req,
  input logic opsum_ack
);

  int fail_cnt; // assertion failures so far

  // --------------------------------------------------
  // load channel
  // --------------------------------------------------
  ack_needs_req: assert property (@(posedge clk) disable iff (!reset)
    $rose(load_ack) |-> $past(load_req))
    else begin
      fail_cnt++;
      $error("load_ack rose without load_req");
    end

  store_one_cycle: assert property (@(posedge clk) disable iff (!reset)
    store |=> !store)
    else begin
      fail_cnt++;
      $error("store strobe wider than one cycle");
    end

  // --------------------------------------------------
  // opsum channel and drain pacing
  // --------------------------------------------------
  req_held: assert property (@(posedge clk) disable iff (!reset)
    opsum_req && !opsum_ack |=> opsum_req)
    else begin
      fail_cnt++;
      $error("opsum_req dropped before opsum_ack");
    end

  no_step_in_beat: assert property (@(posedge clk) disable iff (!reset)
    step |-> !opsum_req)
    else begin
      fail_cnt++;
      $error("step issued while opsum_req high");
    end

endmodule

// top scope sees both handshakes plus the internal store and step nets
bind psum_top psum_asserts u_asserts (
  .clk       (clk),
  .reset     (reset),
  .load_req  (load_req),
  .load_ack  (load_ack),
  .store     (store),
  .step      (step),
  .opsum_req (opsum_req),
  .opsum_ack (opsum_ack)
);

//--- psum_tb.sv
`timescale 1ns/1ps

module psum_tb;

  import psum_pkg::*;

  localparam int rows      = 32;
  localparam int words     = words_per_row * rows; // words per pass
  localparam int max_gap   = 5;                    // source idle cycles
  localparam int max_delay = 6;                    // sink ack delay
  localparam int passes    = 7;
  localparam int word_cyc  = max_gap + 6;
  localparam int beat_cyc  = 2 * max_delay + 8;
  localparam int cycle_limit = 2 * passes * (words * word_cyc + fifo_depth * beat_cyc) + 200;

  logic                        clk;
  logic                        reset;
  logic                        load_req;
  load_word_t                  load_word;
  logic                        load_ack;
  logic [rows-1:0][psum_w-1:0] pe_psum;
  logic [rows-1:0][psum_w-1:0] opsum;
  logic                        opsum_req;
  logic                        opsum_ack;
  logic                        pass_done;

  // --------------------------------------------------
  // reference model state
  // --------------------------------------------------
  logic [psum_w-1:0] mdl_fifo [rows][fifo_depth]; // entry 3 drains first
  int                mdl_row;
  int                mdl_half;
  load_word_t        pass_words [words];          // words of current pass
  int                pass_idx;
  logic [psum_w-1:0] pe_hold [rows];              // pe vector on the bus
  logic [psum_w-1:0] exp_vec [rows];              // expected opsum of beat

  logic [15:0] lfsr_q;
  int          errors;
  int          checks;
  int          cycles;
  bit          pass_seen; // set once pass_done observed

  tb_clock #(.half_period(4.0)) u_clock (.clk(clk));

  psum_top #(.row_num(rows)) UUT (
    .clk       (clk),
    .reset     (reset),
    .load_req  (load_req),
    .load_word (load_word),
    .load_ack  (load_ack),
    .pe_psum   (pe_psum),
    .opsum     (opsum),
    .opsum_req (opsum_req),
    .opsum_ack (opsum_ack),
    .pass_done (pass_done)
  );

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q); // one step per bit
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // high picks values near 0xffff to force wrap
  function automatic logic [psum_w-1:0] rand_psum(input bit high);
    logic [31:0] r;
    r = rand_bits(high ? 8 : 16);
    return high ? {8'hff, r[7:0]} : r[15:0];
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error: %s got %h expected %h", name, got, exp);
    end
  endtask

  // new word lands in entries 0/1 and the older word moves to 2/3
  task automatic model_push(input load_word_t w);
    mdl_fifo[mdl_row][3] = mdl_fifo[mdl_row][1];
    mdl_fifo[mdl_row][2] = mdl_fifo[mdl_row][0];
    mdl_fifo[mdl_row][0] = w.hi;
    mdl_fifo[mdl_row][1] = w.lo;
    pass_words[pass_idx] = w;
    pass_idx = (pass_idx + 1) % words;
    mdl_half = (mdl_half + 1) % words_per_row;
    if (mdl_half == 0) begin
      mdl_row = (mdl_row + 1) % rows; // every second word
    end
  endtask

  // drain pops entry 3, shifts up and refills zero
  task automatic model_pop();
    for (int r = 0; r < rows; r++) begin
      exp_vec[r] = mdl_fifo[r][3] + pe_hold[r]; // mod 2^16
      for (int i = fifo_depth - 1; i > 0; i--) begin
        mdl_fifo[r][i] = mdl_fifo[r][i-1];
      end
      mdl_fifo[r][0] = '0;
    end
  endtask

  task automatic check_opsum(input int beat, input bit order_chk);
    load_word_t        a;
    load_word_t        b;
    logic [psum_w-1:0] ord;
    for (int r = 0; r < rows; r++) begin
      check_value($sformatf("opsum[%0d]", r), opsum[r], exp_vec[r]);
      if (order_chk) begin // beats A.lo A.hi B.lo B.hi with pe zero
        a = pass_words[2*r];
        b = pass_words[2*r+1];
        ord = (beat == 0) ? a.lo : (beat == 1) ? a.hi : (beat == 2) ? b.lo : b.hi;
        check_value($sformatf("opsum[%0d]", r), opsum[r], ord);
      end
    end
  endtask

  // only called with req and ack both low
  task automatic set_pe(input bit rnd);
    for (int r = 0; r < rows; r++) begin
      pe_hold[r] = rnd ? rand_psum(rand_bits(1) == 1) : '0;
      pe_psum[r] <= pe_hold[r];
    end
  endtask

  task automatic send_word(input load_word_t w, input int gap);
    repeat (gap) @(posedge clk);
    load_word <= w;
    load_req  <= 1'b1;
    do @(posedge clk); while (!load_ack);
    load_req <= 1'b0;                     // phase 3
    model_push(w);
    do @(posedge clk); while (load_ack); // phase 4 seen
  endtask

  task automatic load_words(input int n, input bit high, input int gap_max);
    load_word_t w;
    int         gap;
    for (int i = 0; i < n; i++) begin
      w.hi = rand_psum(high);
      w.lo = rand_psum(high);
      gap  = (gap_max > 0) ? rand_bits(3) % (gap_max + 1) : 0;
      send_word(w, gap);
    end
  endtask

  // --------------------------------------------------
  // sink side of one pass
  // --------------------------------------------------
  task automatic drain_pass(input bit slow, input bit order_chk, input bit rnd_pe);
    int wait_cyc;
    for (int beat = 0; beat < fifo_depth; beat++) begin
      do @(posedge clk); while (!opsum_req);
      model_pop();
      check_opsum(beat, order_chk);
      wait_cyc = slow ? rand_bits(3) % (max_delay + 1) : 0;
      repeat (wait_cyc) begin
        @(posedge clk);
        check_value("opsum_req", opsum_req, 1); // held until ack
        check_opsum(beat, 1'b0);                 // data stays put
      end
      opsum_ack <= 1'b1;
      do @(posedge clk); while (opsum_req);
      wait_cyc = slow ? rand_bits(3) % (max_delay + 1) : 0;
      repeat (wait_cyc) @(posedge clk);
      opsum_ack <= 1'b0;
      if (beat < fifo_depth - 1) begin
        set_pe(rnd_pe); // next beat's pe held through its ack
      end
    end
    do @(posedge clk); while (!pass_done);
    pass_seen = 1'b1;
    @(posedge clk);
    check_value("pass_done", pass_done, 0); // single pulse
  endtask

  // word raised mid-drain waits for the pass to end
  task automatic held_word(input load_word_t w);
    do @(posedge clk); while (!opsum_req);
    load_word <= w;
    load_req  <= 1'b1;
    do begin
      @(posedge clk);
      checks++;
      if (load_ack && !pass_seen) begin
        errors++;
        $display("load word was acked while the drain was still running");
      end
    end while (!load_ack);
    load_req <= 1'b0;
    model_push(w);
    do @(posedge clk); while (load_ack);
  endtask

  // --------------------------------------------------
  // directed tests
  // --------------------------------------------------
  task automatic test_reset();
    check_value("opsum_req", opsum_req, 0);
    check_value("load_ack", load_ack, 0);
    check_value("pass_done", pass_done, 0);
    for (int r = 0; r < rows; r++) begin
      check_value($sformatf("opsum[%0d]", r), opsum[r], 0);
    end
  endtask

  task automatic test_full_pass();
    set_pe(1'b0);
    load_words(words, 1'b0, 0);
    drain_pass(1'b0, 1'b1, 1'b0);
  endtask

  task automatic test_accumulate();
    set_pe(1'b1);
    load_words(words, 1'b1, 0); // ipsums near 0xffff
    drain_pass(1'b0, 1'b0, 1'b1);
  endtask

  task automatic test_backpressure();
    set_pe(1'b0);
    load_words(words, 1'b0, 0);
    drain_pass(1'b1, 1'b1, 1'b0);
  endtask

  task automatic test_stall_source();
    load_word_t w;
    set_pe(1'b0);
    load_words(words, 1'b0, max_gap);
    w.hi = rand_psum(1'b0); // held word data
    w.lo = rand_psum(1'b0);
    pass_seen = 1'b0;
    fork
      drain_pass(1'b0, 1'b1, 1'b0);
      held_word(w);
    join
    set_pe(1'b0);
    load_words(words - 1, 1'b0, max_gap); // held word opened this pass
    drain_pass(1'b0, 1'b1, 1'b0);
  endtask

  task automatic test_back_to_back();
    set_pe(1'b0);
    load_words(words, 1'b0, 0);
    drain_pass(1'b0, 1'b1, 1'b0);
    load_words(words, 1'b0, 0); // fresh data only
    drain_pass(1'b0, 1'b1, 1'b0);
  endtask

  // --------------------------------------------------
  // run limit
  // --------------------------------------------------
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      errors++;
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("errors: %0d, checks: %0d", errors, checks);
      $display("** FAIL **");
      $finish;
    end
  end

  initial begin
    lfsr_q    = 16'd25;
    reset     = 1'b0;
    load_req  = 1'b0;
    load_word = '0;
    pe_psum   = '0;
    opsum_ack = 1'b0;
    mdl_row   = 0;
    mdl_half  = 0;
    pass_idx  = 0;
    for (int r = 0; r < rows; r++) begin
      pe_hold[r] = '0;
      for (int i = 0; i < fifo_depth; i++) begin
        mdl_fifo[r][i] = '0;
      end
    end
    repeat (8) @(posedge clk);
    reset <= 1'b1;
    @(posedge clk);
    test_reset();
    test_full_pass();
    test_accumulate();
    test_backpressure();
    test_stall_source();
    test_back_to_back();
    errors += UUT.u_asserts.fail_cnt; // bound checker failures
    $display("errors: %0d, checks: %0d", errors, checks);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- psum_path.f
psum_pkg.sv
ipsum_loader.sv
ipsum_buffer.sv
psum_reducer.sv
psum_ctrl.sv
psum_top.sv
tb_clock.sv
psum_asserts.sv
psum_tb.sv

//--- Bender.yml
package:
  name: psum_path

sources:
  - psum_pkg.sv
  - ipsum_loader.sv
  - ipsum_buffer.sv
  - psum_reducer.sv
  - psum_ctrl.sv
  - psum_top.sv
  - target: simulation
    files:
      - tb_clock.sv
      - psum_asserts.sv
      - psum_tb.sv
